//--- all.f
logic/rv_core_pkg.sv
logic/reg_file.sv
logic/alu.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/forward_unit.sv
logic/execute_stage.sv
logic/rv_pipeline_top.sv
tb/rv_pipeline_assertions.sv
tb/rv_pipeline_checker.sv
tb/rv_pipeline_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module rv_pipeline_tb \
		-f all.f --Mdir obj_dir -o rv_pipeline_sim
	./obj_dir/rv_pipeline_sim | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/rv_pipeline_tb.sv
`timescale 1ns/1ps

module rv_pipeline_tb import rv_core_pkg::*; ();

  localparam logic [XLEN-1:0] RESET_PC = '0;
  localparam int PROG_LEN     = 150;
  localparam int RESET_CYCLES = 5;
  localparam int PIPE_DEPTH   = 3;
  localparam int NUM_TESTS    = 5;
  localparam int MAX_CYCLES   = NUM_TESTS * (PROG_LEN + PIPE_DEPTH + RESET_CYCLES) + 50;
  localparam logic [31:0] SEED = 32'h66927d9b;

  logic                  clk;
  logic                  rst_n_i;
  logic [XLEN-1:0]       inst_i;
  logic [XLEN-1:0]       pc_o;
  logic                  wb_valid_o;
  logic [REG_ADDR_W-1:0] wb_rd_o;
  logic [XLEN-1:0]       wb_data_o;
  logic [31:0]           prog [0:PROG_LEN-1];
  int                    retired, checks, errors;
  int                    cycles = 0;
  int                    fails;

  rv_pipeline_top #(.RESET_PC(RESET_PC)) DUT (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .inst_i     (inst_i),
    .pc_o       (pc_o),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o)
  );

  rv_pipeline_checker #(.RESET_PC(RESET_PC), .PROG_LEN(PROG_LEN)) u_checker (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .inst_i     (inst_i),
    .pc_i       (pc_o),
    .wb_valid_i (wb_valid_o),
    .wb_rd_i    (wb_rd_o),
    .wb_data_i  (wb_data_o),
    .retired_o  (retired),
    .checks_o   (checks),
    .errors_o   (errors)
  );

  bind execute_stage rv_pipeline_assertions u_assertions (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .pc_ex        (pc_ex),
    .rd_wb        (rd_wb),
    .reg_write_wb (reg_write_wb),
    .fwd1_ex      (fwd1_ex),
    .fwd2_ex      (fwd2_ex)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ========================================
  // instruction encoding
  // ========================================
  function automatic logic [31:0] r_word(input logic [2:0] f3, input logic alt,
                                         input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [4:0] rd);
    logic [6:0] f7;
    // only add/sub and the right shifts have an alternate form
    f7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_word(input logic [2:0] f3, input logic alt,
                                         input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [4:0] rd);
    logic [11:0] imm_f;
    imm_f = imm;
    if (f3 == 3'b001) begin
      imm_f = {7'b0, imm[4:0]};
    end else if (f3 == 3'b101) begin
      imm_f = {alt ? 7'b0100000 : 7'b0000000, imm[4:0]};
    end
    return {imm_f, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] u_word(input logic auipc, input logic [19:0] imm,
                                         input logic [4:0] rd);
    return {imm, rd, auipc ? 7'b0010111 : 7'b0110111};
  endfunction

  // load, store, branch, jal and system all travel as bubbles
  function automatic logic [31:0] illegal_word();
    logic [31:0] raw;
    logic [6:0]  opc;
    raw = $urandom();
    case ($urandom_range(4, 0))
      0:       opc = 7'b0000011;
      1:       opc = 7'b0100011;
      2:       opc = 7'b1100011;
      3:       opc = 7'b1101111;
      default: opc = 7'b1110011;
    endcase
    return {raw[31:7], opc};
  endfunction

  function automatic logic [31:0] random_inst(input int cls);
    logic [31:0] raw;
    logic [4:0]  rd, rs1, rs2;
    int          kind;
    raw  = $urandom();
    rd   = 5'($urandom_range(15, 0));
    rs1  = 5'($urandom_range(15, 0));
    rs2  = 5'($urandom_range(15, 0));
    kind = cls;
    if (cls == 2) begin
      kind = ($urandom_range(3, 0) == 0) ? 0 : 2;
    end
    if (cls == 3) begin
      // four registers, so most operands were written one or two slots back
      rd   = 5'($urandom_range(4, 1));
      rs1  = 5'($urandom_range(4, 1));
      rs2  = 5'($urandom_range(4, 1));
      kind = $urandom_range(2, 0);
    end
    if (cls == 4) begin
      kind = $urandom_range(3, 0);
      rd   = raw[0] ? 5'd0 : rd;
      rs1  = raw[1] ? 5'd0 : rs1;
    end
    case (kind)
      0:       return r_word(raw[14:12], raw[30], rs2, rs1, rd);
      1:       return i_word(raw[14:12], raw[30], raw[31:20], rs1, rd);
      2:       return u_word(raw[2], raw[31:12], rd);
      default: return illegal_word();
    endcase
  endfunction

  task automatic build_program(input int cls);
    for (int i = 0; i < PROG_LEN; i++) begin
      if (i < 16) begin
        // prologue gives x1..x8 random values via lui then addi
        if (i % 2 == 0) begin
          prog[i] = u_word(1'b0, 20'($urandom()), 5'(i / 2 + 1));
        end else begin
          prog[i] = i_word(3'b000, 1'b0, 12'($urandom()), 5'(i / 2 + 1), 5'(i / 2 + 1));
        end
      end else begin
        prog[i] = random_inst(cls);
      end
    end
  endtask

  function automatic logic [31:0] fetch_word(input logic [XLEN-1:0] pc);
    logic [XLEN-1:0] idx;
    if ($isunknown(pc)) begin
      return NOP_INST;
    end
    idx = (pc - RESET_PC) >> 2;
    return (idx < PROG_LEN) ? prog[idx] : NOP_INST;
  endfunction

  function automatic string test_name(input int cls);
    case (cls)
      0:       return "r_type";
      1:       return "i_type";
      2:       return "upper_imm";
      3:       return "dependency";
      default: return "bubble_x0";
    endcase
  endfunction

  task automatic apply_reset();
    rst_n_i = 1'b0;
    inst_i  = NOP_INST;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n_i = 1'b1;
    inst_i  = fetch_word(pc_o);
  endtask

  // ========================================
  // test sequence
  // ========================================
  initial begin
    rst_n_i = 1'b0;
    inst_i  = NOP_INST;
    void'($urandom(SEED));
    for (int t = 0; t < NUM_TESTS; t++) begin
      build_program(t);
      apply_reset();
      while (retired < PROG_LEN) begin
        @(negedge clk);
        inst_i = fetch_word(pc_o);
      end
      u_checker.end_test(test_name(t));
    end
    fails = errors + DUT.u_execute.u_assertions.fail_count;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             NUM_TESTS, checks, errors, DUT.u_execute.u_assertions.fail_count);
    if (fails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: programs still retiring after %0d cycles", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

endmodule

//--- tb/rv_pipeline_checker.sv
`timescale 1ns/1ps

module rv_pipeline_checker import rv_core_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0,
  parameter int              PROG_LEN = 150
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic [XLEN-1:0]       inst_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic                  wb_valid_i,
  input  logic [REG_ADDR_W-1:0] wb_rd_i,
  input  logic [XLEN-1:0]       wb_data_i,
  output int                    retired_o,
  output int                    checks_o,
  output int                    errors_o
);

  localparam int DEPTH = 3;

  logic [XLEN-1:0] model_regs [0:31];
  logic [XLEN-1:0] inst_q [$];
  logic [XLEN-1:0] pc_q [$];
  logic [XLEN-1:0] exp_pc;
  logic [XLEN-1:0] old_inst, old_pc;
  logic [XLEN-1:0] exp_data;
  logic [4:0]      exp_rd;
  logic            exp_we;
  int              test_checks = 0;
  int              test_errors = 0;
  int              total_checks = 0;
  int              total_errors = 0;
  int              retired = 0;

  assign retired_o = retired;
  assign checks_o  = total_checks;
  assign errors_o  = total_errors;

  task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                             input logic [XLEN-1:0] actual);
    test_checks++;
    total_checks++;
    if (actual !== expected) begin
      test_errors++;
      total_errors++;
      $display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  // ========================================
  // reference model, straight from the ISA
  // ========================================
  function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? XLEN'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic predict(input logic [XLEN-1:0] inst, input logic [XLEN-1:0] pc,
                         output logic we, output logic [4:0] rd,
                         output logic [XLEN-1:0] value);
    logic [XLEN-1:0] a, b, imm_i, imm_u;
    logic [2:0]      f3;
    rd    = inst[11:7];
    f3    = inst[14:12];
    a     = model_regs[inst[19:15]];
    b     = model_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_u = {inst[31:12], 12'b0};
    we    = (rd != 5'd0);
    value = '0;
    case (inst[6:0])
      7'b0110011: value = alu_ref(f3, inst[30], a, b);
      // bit 30 only selects srai among the immediate forms
      7'b0010011: value = alu_ref(f3, inst[30] && (f3 == 3'b101), a, imm_i);
      7'b0110111: value = imm_u;
      7'b0010111: value = pc + imm_u;
      default:    we = 1'b0;
    endcase
  endtask

  always @(posedge clk) begin
    if (!rst_n_i) begin
      inst_q.delete();
      pc_q.delete();
      for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
      end
      exp_pc  = RESET_PC;
      retired = 0;
    end else begin
      check_value("pc_o", exp_pc, pc_i);
      exp_pc = exp_pc + XLEN'(4);
      exp_we = 1'b0;
      // entry fetched three edges ago is due now
      if (inst_q.size() == DEPTH) begin
        old_inst = inst_q.pop_front();
        old_pc   = pc_q.pop_front();
        predict(old_inst, old_pc, exp_we, exp_rd, exp_data);
        if (((old_pc - RESET_PC) >> 2) < PROG_LEN) begin
          retired++;
        end
      end
      check_value("wb_valid_o", XLEN'(exp_we), XLEN'(wb_valid_i));
      if (exp_we) begin
        check_value("wb_rd_o", XLEN'(exp_rd), XLEN'(wb_rd_i));
        check_value("wb_data_o", exp_data, wb_data_i);
        model_regs[exp_rd] = exp_data;
      end
      inst_q.push_back(inst_i);
      pc_q.push_back(pc_i);
    end
  end

endmodule

//--- tb/rv_pipeline_assertions.sv
`timescale 1ns/1ps

module rv_pipeline_assertions import rv_core_pkg::*; (
  input logic                  clk,
  input logic                  rst_n_i,
  input logic [XLEN-1:0]       pc_ex,
  input logic [REG_ADDR_W-1:0] rd_wb,
  input logic                  reg_write_wb,
  input logic                  fwd1_ex,
  input logic                  fwd2_ex
);

  int fail_count = 0;

  // reset bubbles drain for three cycles, nothing may retire meanwhile
  wb_quiet_after_reset: assert property (@(posedge clk)
    (rst_n_i && !$past(rst_n_i, 3)) |-> !reg_write_wb)
    else begin
      $error("writeback seen in the first cycles after reset");
      fail_count++;
    end

  // pc reaches execute two cycles late, so it steps by 4 there too
  pc_step_of_four: assert property (@(posedge clk)
    (rst_n_i && $past(rst_n_i) && $past(rst_n_i, 2) && $past(rst_n_i, 3))
      |-> (pc_ex == $past(pc_ex) + XLEN'(4)))
    else begin
      $error("pc did not advance by 4");
      fail_count++;
    end

  // x0 is never a forwarding source
  no_forward_from_x0: assert property (@(posedge clk)
    (rst_n_i && (rd_wb == '0)) |-> (!fwd1_ex && !fwd2_ex))
    else begin
      $error("forward select raised for a write to x0");
      fail_count++;
    end

endmodule

//--- logic/rv_pipeline_top.sv
`timescale 1ns/1ps

module rv_pipeline_top import rv_core_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic [XLEN-1:0]       inst_i,
  output logic [XLEN-1:0]       pc_o,
  output logic                  wb_valid_o,
  output logic [REG_ADDR_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]       wb_data_o
);

  logic [XLEN-1:0]       pc_id, inst_id;
  logic [REG_ADDR_W-1:0] rs1_id, rs2_id;
  logic [REG_ADDR_W-1:0] rs1_ex, rs2_ex, rd_ex;
  logic [XLEN-1:0]       pc_ex, rdata1_ex, rdata2_ex, imm_ex;
  alu_op_t               alu_op_ex;
  logic                  alu_src_ex, auipc_ex, reg_write_ex;
  logic                  bypass1_id, bypass2_id;
  logic                  fwd1_ex, fwd2_ex;

  fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .inst_i  (inst_i),
    .pc_o    (pc_o),
    .pc_id   (pc_id),
    .inst_id (inst_id)
  );

  // writeback outputs double as the register-file write port
  decode_stage u_decode (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .pc_id        (pc_id),
    .inst_id      (inst_id),
    .bypass1_id   (bypass1_id),
    .bypass2_id   (bypass2_id),
    .rd_wb        (wb_rd_o),
    .result_wb    (wb_data_o),
    .reg_write_wb (wb_valid_o),
    .rs1_id       (rs1_id),
    .rs2_id       (rs2_id),
    .rs1_ex       (rs1_ex),
    .rs2_ex       (rs2_ex),
    .rd_ex        (rd_ex),
    .pc_ex        (pc_ex),
    .rdata1_ex    (rdata1_ex),
    .rdata2_ex    (rdata2_ex),
    .imm_ex       (imm_ex),
    .alu_op_ex    (alu_op_ex),
    .alu_src_ex   (alu_src_ex),
    .auipc_ex     (auipc_ex),
    .reg_write_ex (reg_write_ex)
  );

  forward_unit u_forward (
    .rs1_id       (rs1_id),
    .rs2_id       (rs2_id),
    .rs1_ex       (rs1_ex),
    .rs2_ex       (rs2_ex),
    .rd_wb        (wb_rd_o),
    .reg_write_wb (wb_valid_o),
    .bypass1_id   (bypass1_id),
    .bypass2_id   (bypass2_id),
    .fwd1_ex      (fwd1_ex),
    .fwd2_ex      (fwd2_ex)
  );

  execute_stage u_execute (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .rd_ex        (rd_ex),
    .pc_ex        (pc_ex),
    .rdata1_ex    (rdata1_ex),
    .rdata2_ex    (rdata2_ex),
    .imm_ex       (imm_ex),
    .alu_op_ex    (alu_op_ex),
    .alu_src_ex   (alu_src_ex),
    .auipc_ex     (auipc_ex),
    .reg_write_ex (reg_write_ex),
    .fwd1_ex      (fwd1_ex),
    .fwd2_ex      (fwd2_ex),
    .rd_wb        (wb_rd_o),
    .result_wb    (wb_data_o),
    .reg_write_wb (wb_valid_o)
  );

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv_core_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic [REG_ADDR_W-1:0] rd_ex,
  input  logic [XLEN-1:0]       pc_ex,
  input  logic [XLEN-1:0]       rdata1_ex,
  input  logic [XLEN-1:0]       rdata2_ex,
  input  logic [XLEN-1:0]       imm_ex,
  input  alu_op_t               alu_op_ex,
  input  logic                  alu_src_ex,
  input  logic                  auipc_ex,
  input  logic                  reg_write_ex,
  input  logic                  fwd1_ex,
  input  logic                  fwd2_ex,
  output logic [REG_ADDR_W-1:0] rd_wb,
  output logic [XLEN-1:0]       result_wb,
  output logic                  reg_write_wb
);

  logic [XLEN-1:0] src1, src2;
  logic [XLEN-1:0] op_a, op_b;
  logic [XLEN-1:0] alu_result;

  // forwarding from the EX/WB register
  assign src1 = fwd1_ex ? result_wb : rdata1_ex;
  assign src2 = fwd2_ex ? result_wb : rdata2_ex;

  // operand select
  assign op_a = auipc_ex ? pc_ex : src1;
  assign op_b = alu_src_ex ? imm_ex : src2;

  alu u_alu (
    .op_i     (alu_op_ex),
    .a_i      (op_a),
    .b_i      (op_b),
    .result_o (alu_result)
  );

  // ========================================
  // EX/WB register
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      reg_write_wb <= 1'b0;
    end else begin
      reg_write_wb <= reg_write_ex;
    end
  end

  always_ff @(posedge clk) begin
    rd_wb     <= rd_ex;
    result_wb <= alu_result;
  end

endmodule

//--- logic/forward_unit.sv
`timescale 1ns/1ps

module forward_unit import rv_core_pkg::*; (
  input  logic [REG_ADDR_W-1:0] rs1_id,
  input  logic [REG_ADDR_W-1:0] rs2_id,
  input  logic [REG_ADDR_W-1:0] rs1_ex,
  input  logic [REG_ADDR_W-1:0] rs2_ex,
  input  logic [REG_ADDR_W-1:0] rd_wb,
  input  logic                  reg_write_wb,
  output logic                  bypass1_id,
  output logic                  bypass2_id,
  output logic                  fwd1_ex,
  output logic                  fwd2_ex
);

  logic wb_live;

  // only a real write to a nonzero register can be forwarded
  assign wb_live = reg_write_wb && (rd_wb != '0);

  // distance 2, consumer still in decode
  assign bypass1_id = wb_live && (rs1_id == rd_wb);
  assign bypass2_id = wb_live && (rs2_id == rd_wb);

  // distance 1, consumer in execute
  assign fwd1_ex = wb_live && (rs1_ex == rd_wb);
  assign fwd2_ex = wb_live && (rs2_ex == rd_wb);

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_core_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic [XLEN-1:0]       pc_id,
  input  logic [XLEN-1:0]       inst_id,
  input  logic                  bypass1_id,
  input  logic                  bypass2_id,
  input  logic [REG_ADDR_W-1:0] rd_wb,
  input  logic [XLEN-1:0]       result_wb,
  input  logic                  reg_write_wb,
  output logic [REG_ADDR_W-1:0] rs1_id,
  output logic [REG_ADDR_W-1:0] rs2_id,
  output logic [REG_ADDR_W-1:0] rs1_ex,
  output logic [REG_ADDR_W-1:0] rs2_ex,
  output logic [REG_ADDR_W-1:0] rd_ex,
  output logic [XLEN-1:0]       pc_ex,
  output logic [XLEN-1:0]       rdata1_ex,
  output logic [XLEN-1:0]       rdata2_ex,
  output logic [XLEN-1:0]       imm_ex,
  output alu_op_t               alu_op_ex,
  output logic                  alu_src_ex,
  output logic                  auipc_ex,
  output logic                  reg_write_ex
);

  opcode_t               opcode;
  logic [REG_ADDR_W-1:0] rd_id;
  logic [2:0]            funct3;
  logic                  funct7_5;
  logic [XLEN-1:0]       rf_rdata1, rf_rdata2;
  logic [XLEN-1:0]       rdata1_id, rdata2_id;
  logic [XLEN-1:0]       imm_id;
  alu_op_t               alu_op_id;
  logic                  alu_src_id, auipc_id, writes_rd;

  // shared funct3 decode, sub only exists for register ops
  function automatic alu_op_t funct_to_alu(input logic [2:0] f3, input logic alt,
                                           input logic is_reg);
    alu_op_t op;
    case (f3)
      3'b000:  op = (alt && is_reg) ? SUB : ADD;
      3'b001:  op = SLL;
      3'b010:  op = SLT;
      3'b011:  op = SLTU;
      3'b100:  op = XOR;
      3'b101:  op = alt ? SRA : SRL;
      3'b110:  op = OR;
      default: op = AND;
    endcase
    return op;
  endfunction

  // ========================================
  // field split
  // ========================================
  assign opcode   = opcode_t'(inst_id[6:0]);
  assign rd_id    = inst_id[11:7];
  assign funct3   = inst_id[14:12];
  assign rs1_id   = inst_id[19:15];
  assign rs2_id   = inst_id[24:20];
  assign funct7_5 = inst_id[30];

  // control and immediate
  always_comb begin
    alu_op_id  = ADD;
    alu_src_id = 1'b0;
    auipc_id   = 1'b0;
    writes_rd  = 1'b0;
    imm_id     = {{(XLEN-12){inst_id[31]}}, inst_id[31:20]};
    case (opcode)
      OP: begin
        alu_op_id = funct_to_alu(funct3, funct7_5, 1'b1);
        writes_rd = 1'b1;
      end
      OP_IMM: begin
        alu_op_id  = funct_to_alu(funct3, funct7_5, 1'b0);
        alu_src_id = 1'b1;
        writes_rd  = 1'b1;
      end
      LUI: begin
        alu_op_id  = PASS_B;
        alu_src_id = 1'b1;
        writes_rd  = 1'b1;
        imm_id     = {inst_id[31:12], 12'b0};
      end
      AUIPC: begin
        alu_src_id = 1'b1;
        auipc_id   = 1'b1;
        writes_rd  = 1'b1;
        imm_id     = {inst_id[31:12], 12'b0};
      end
      default: begin
        // unsupported opcode travels as a bubble
        writes_rd = 1'b0;
      end
    endcase
  end

  reg_file u_reg_file (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .we_i     (reg_write_wb),
    .waddr_i  (rd_wb),
    .wdata_i  (result_wb),
    .raddr1_i (rs1_id),
    .raddr2_i (rs2_id),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2)
  );

  // value written this cycle is not in the file yet
  assign rdata1_id = bypass1_id ? result_wb : rf_rdata1;
  assign rdata2_id = bypass2_id ? result_wb : rf_rdata2;

  // ========================================
  // ID/EX register
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      reg_write_ex <= 1'b0;
    end else begin
      // x0 destinations never count as a write
      reg_write_ex <= writes_rd && (rd_id != '0);
    end
  end

  always_ff @(posedge clk) begin
    rs1_ex     <= rs1_id;
    rs2_ex     <= rs2_id;
    rd_ex      <= rd_id;
    pc_ex      <= pc_id;
    rdata1_ex  <= rdata1_id;
    rdata2_ex  <= rdata2_id;
    imm_ex     <= imm_id;
    alu_op_ex  <= alu_op_id;
    alu_src_ex <= alu_src_id;
    auipc_ex   <= auipc_id;
  end

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import rv_core_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic [XLEN-1:0] inst_i,
  output logic [XLEN-1:0] pc_o,
  output logic [XLEN-1:0] pc_id,
  output logic [XLEN-1:0] inst_id
);

  logic [XLEN-1:0] pc_plus_4;

  assign pc_plus_4 = pc_o + XLEN'(4);

  // program counter, never redirected
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_o <= RESET_PC;
    end else begin
      pc_o <= pc_plus_4;
    end
  end

  // ========================================
  // IF/ID register
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_id   <= RESET_PC;
      inst_id <= NOP_INST;
    end else begin
      pc_id   <= pc_o;
      inst_id <= inst_i;
    end
  end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu import rv_core_pkg::*; (
  input  alu_op_t         op_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] result_o
);

  logic [4:0] shamt;

  // shift amount from the low bits only
  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ADD:    result_o = a_i + b_i;
      SUB:    result_o = a_i - b_i;
      SLL:    result_o = a_i << shamt;
      SLT:    result_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      SLTU:   result_o = {{(XLEN-1){1'b0}}, a_i < b_i};
      XOR:    result_o = a_i ^ b_i;
      SRL:    result_o = a_i >> shamt;
      SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
      OR:     result_o = a_i | b_i;
      AND:    result_o = a_i & b_i;
      // lui just takes the upper immediate
      PASS_B: result_o = b_i;
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_core_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i,
  input  logic [REG_ADDR_W-1:0] raddr1_i,
  input  logic [REG_ADDR_W-1:0] raddr2_i,
  output logic [XLEN-1:0]       rdata1_o,
  output logic [XLEN-1:0]       rdata2_o
);

  logic [XLEN-1:0] regs [0:(1<<REG_ADDR_W)-1];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < (1 << REG_ADDR_W); i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 is hardwired
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- logic/rv_core_pkg.sv
package rv_core_pkg;

  // ========================================
  // widths
  // ========================================
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // addi x0, x0, 0 used as the pipeline bubble
  localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

  // ========================================
  // opcodes handled by the core
  // ========================================
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111
  } opcode_t;

  // alu operations
  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    SLL    = 4'd2,
    SLT    = 4'd3,
    SLTU   = 4'd4,
    XOR    = 4'd5,
    SRL    = 4'd6,
    SRA    = 4'd7,
    OR     = 4'd8,
    AND    = 4'd9,
    PASS_B = 4'd10
  } alu_op_t;

endpackage
